/* sources.f */
logic/cart_bus_pkg.sv
logic/bus_demux.sv
logic/config_port.sv
logic/sector_buffer.sv
logic/cart_bus_driver.sv
logic/cart_top.sv
tests/tb_clock.sv
tests/cart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cartridge bus testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing -j 0 --timescale 1ns/10ps -Mdir obj_dir \
    --top-module cart_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vcart_tb 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

/* tests/cart_tb.sv */
`timescale 1ns/10ps

module cart_tb;
    import cart_bus_pkg::*;

    typedef enum logic [1:0] {
        IO_WR,
        MEM_WR,
        MEM_RD
    } op_kind_e;

    typedef struct packed {
        op_kind_e     kind;
        cpu_addr_t    addr;
        cpu_data_t    data;
        cpu_data_t    exp_rd;       // only used by reads
        mapper_type_e exp_map;
        logic         exp_scc_en;
        vol_t         exp_scc_vol;
        vol_t         exp_psg_vol;
        vol_t         exp_opll_vol;
        logic         exp_sd_en;
    } stim_t;

    localparam cpu_data_t FLAGS_IO   = 8'hFD;   // iorq_n low
    localparam cpu_data_t FLAGS_MEM  = 8'hFE;   // merq_n low
    localparam cpu_data_t FLAGS_IDLE = 8'hFF;

    logic         clk108_w;
    logic         ram_enabled_w;
    cpu_data_t    mp;
    logic         rd_n;
    logic         wr_n;
    logic         sltsl_n;
    cpu_data_t    cd_in;
    msel_t        msel_n;
    cpu_data_t    cd_out;
    logic         datadir;
    logic         sd_enabled;
    mapper_type_e mapper_type;
    logic         scc_enable;
    vol_t         scc_vol;
    vol_t         psg_vol;
    vol_t         opll_vol;

    cpu_addr_t    pend_addr;            // what the cpu puts on the mux
    cpu_data_t    pend_flags;
    stim_t        table_q [$];
    cpu_data_t    shadow [512];         // expected buffer contents
    logic [8:0]   offs [20];
    logic [31:0]  rng_state;
    mapper_type_e m_map;
    logic         m_scc_en;
    vol_t         m_scc_vol;
    vol_t         m_psg_vol;
    vol_t         m_opll_vol;
    logic         m_sd_en;

    tb_clock #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) u_clock (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w)
    );

    cart_top #(
        .SYNC_STAGES (2)
    ) UUT (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .cd_in         (cd_in),
        .msel_n        (msel_n),
        .cd_out        (cd_out),
        .datadir       (datadir),
        .sd_enabled    (sd_enabled),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable),
        .scc_vol       (scc_vol),
        .psg_vol       (psg_vol),
        .opll_vol      (opll_vol)
    );

    // cpu side of the address mux following msel_n
    initial begin : mux_model
        mp = FLAGS_IDLE;
        forever begin
            @(negedge clk108_w);
            case (msel_n)
                3'b110:  mp = pend_addr[7:0];
                3'b101:  mp = pend_addr[15:8];
                3'b011:  mp = pend_flags;
                default: mp = FLAGS_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input cpu_data_t exp, input cpu_data_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %02h actual %02h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mapper(input string name, input mapper_type_e exp,
                                input mapper_type_e act);
        if (act !== exp) begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_vol(input string name, input vol_t exp, input vol_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_msel(input string name, input msel_t exp, input msel_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic string entry_name(input int idx, input string what);
        return $sformatf("entry %0d %s", idx, what);
    endfunction

    task automatic check_state(input int idx, input stim_t e);
        check_mapper(entry_name(idx, "mapper_type"), e.exp_map, mapper_type);
        check_bit(entry_name(idx, "scc_enable"), e.exp_scc_en, scc_enable);
        check_vol(entry_name(idx, "scc_vol"), e.exp_scc_vol, scc_vol);
        check_vol(entry_name(idx, "psg_vol"), e.exp_psg_vol, psg_vol);
        check_vol(entry_name(idx, "opll_vol"), e.exp_opll_vol, opll_vol);
        check_bit(entry_name(idx, "sd_enabled"), e.exp_sd_en, sd_enabled);
    endtask

    function automatic bit state_matches(input stim_t e);
        return (mapper_type === e.exp_map) && (scc_enable === e.exp_scc_en) &&
               (scc_vol === e.exp_scc_vol) && (psg_vol === e.exp_psg_vol) &&
               (opll_vol === e.exp_opll_vol) && (sd_enabled === e.exp_sd_en);
    endfunction

    ////////////////////////////////////////////////////////////
    // waits and bus cycles
    ////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk108_w);
        end
    endtask

    task automatic wait_msel(input msel_t target, input int limit);
        int cnt;
        cnt = 0;
        while (msel_n !== target && cnt < limit) begin
            @(negedge clk108_w);
            cnt++;
        end
        if (msel_n !== target) begin
            $display("timeout: msel_n never reached %b", target);
            abort_run();
        end
    endtask

    // at least the strobe latency and then until the registers settle
    task automatic wait_effect(input stim_t e, input int settle, input int limit);
        int cnt;
        cnt = 0;
        while (cnt < limit && !(cnt >= settle && state_matches(e))) begin
            @(negedge clk108_w);
            cnt++;
        end
    endtask

    task automatic release_bus();
        wr_n       = 1'b1;
        rd_n       = 1'b1;
        sltsl_n    = 1'b1;
        pend_flags = FLAGS_IDLE;
        wait_cycles(4);
    endtask

    task automatic write_cycle(input stim_t e, input cpu_data_t flags, input logic slot_n);
        pend_addr  = e.addr;
        pend_flags = flags;
        cd_in      = e.data;
        wait_cycles(16);
        sltsl_n = slot_n;
        wr_n    = 1'b0;
        wait_effect(e, 6, 14);
        release_bus();
    endtask

    task automatic io_write(input stim_t e);
        write_cycle(e, FLAGS_IO, 1'b1);
    endtask

    task automatic mem_write(input stim_t e);
        write_cycle(e, FLAGS_MEM, 1'b0);
    endtask

    task automatic mem_read(input stim_t e, output cpu_data_t got);
        int cnt;
        pend_addr  = e.addr;
        pend_flags = FLAGS_MEM;
        wait_cycles(16);
        sltsl_n = 1'b0;
        rd_n    = 1'b0;
        cnt     = 0;
        while (datadir !== 1'b0 && cnt < 10) begin
            @(negedge clk108_w);
            cnt++;
        end
        if (datadir !== 1'b0) begin
            $display("timeout: datadir did not turn around for a slot read");
            abort_run();
        end
        wait_cycles(8);
        got = cd_out;
        release_bus();
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic vol_t expected_vol(input vol_t atten);
        return 4'd9 - atten;    // mod 16
    endfunction

    // expected values follow the cartridge register rules
    function automatic void add_entry(input op_kind_e kind, input cpu_addr_t a,
                                      input cpu_data_t d);
        stim_t e;
        logic  in_win;
        in_win   = (a >= 16'h7C00) && (a < 16'h7E00);
        e.exp_rd = 8'hFF;
        if (kind == MEM_RD) begin
            if (a == 16'h7E00) begin
                e.exp_rd = {7'b0, m_sd_en};
            end else if (m_sd_en && in_win) begin
                e.exp_rd = shadow[a[8:0]];
            end
        end else if (kind == IO_WR && a[7:0] == 8'h8F) begin
            case (d)
                8'h04: begin
                    m_map    = MAP_KONAMI;
                    m_scc_en = 1'b0;
                end
                8'h05: begin
                    m_map    = MAP_KONAMI_SCC;
                    m_scc_en = 1'b1;
                end
                8'h16: begin
                    m_map    = MAP_ASCII16;
                    m_scc_en = 1'b0;
                end
                8'h08: begin
                    m_map    = MAP_ASCII8;
                    m_scc_en = 1'b0;
                end
                default: ;
            endcase
            case (d[7:4])
                4'hF:    m_scc_vol  = expected_vol(d[3:0]);
                4'hE:    m_psg_vol  = expected_vol(d[3:0]);
                4'hD:    m_opll_vol = expected_vol(d[3:0]);
                default: ;
            endcase
        end else if (kind == MEM_WR) begin
            if (a == 16'h7E00) begin
                m_sd_en = d[0];
            end else if (m_sd_en && in_win) begin
                shadow[a[8:0]] = d;
            end
        end
        e.kind         = kind;
        e.addr         = a;
        e.data         = d;
        e.exp_map      = m_map;
        e.exp_scc_en   = m_scc_en;
        e.exp_scc_vol  = m_scc_vol;
        e.exp_psg_vol  = m_psg_vol;
        e.exp_opll_vol = m_opll_vol;
        e.exp_sd_en    = m_sd_en;
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        m_map      = MAP_KONAMI_SCC;
        m_scc_en   = 1'b1;
        m_scc_vol  = 4'd0;
        m_psg_vol  = 4'd0;
        m_opll_vol = 4'd0;
        m_sd_en    = 1'b0;
        rng_state  = 32'd98;
        // mapper opcodes and then one to the wrong port
        add_entry(IO_WR, 16'h008F, 8'h04);
        add_entry(IO_WR, 16'h008F, 8'h05);
        add_entry(IO_WR, 16'h008F, 8'h16);
        add_entry(IO_WR, 16'h008F, 8'h08);
        add_entry(IO_WR, 16'h008E, 8'h05);
        // volumes
        add_entry(IO_WR, 16'h008F, 8'hF3);
        add_entry(IO_WR, 16'h008F, 8'hE2);
        add_entry(IO_WR, 16'h008F, 8'hDC);  // wraps to 13
        add_entry(IO_WR, 16'h008F, 8'hF0);
        add_entry(IO_WR, 16'h008F, 8'h25);
        // buffer still off
        add_entry(MEM_RD, 16'h7C00, 8'h00);
        add_entry(MEM_RD, 16'h7E00, 8'h00);
        // enable and a random round trip
        add_entry(MEM_WR, 16'h7E00, 8'h01);
        add_entry(MEM_RD, 16'h7E00, 8'h00);
        for (int k = 0; k < 20; k++) begin
            rng_state = xorshift32(rng_state);
            offs[k]   = rng_state[8:0];
            rng_state = xorshift32(rng_state);
            add_entry(MEM_WR, 16'h7C00 + {7'b0, offs[k]}, rng_state[7:0]);
        end
        for (int k = 0; k < 20; k++) begin
            add_entry(MEM_RD, 16'h7C00 + {7'b0, offs[k]}, 8'h00);
        end
        add_entry(MEM_RD, 16'h7E10, 8'h00);
        // disable again
        add_entry(MEM_WR, 16'h7E00, 8'h00);
        add_entry(MEM_RD, 16'h7E00, 8'h00);
        add_entry(MEM_RD, 16'h7C00 + {7'b0, offs[0]}, 8'h00);
        add_entry(MEM_RD, 16'h7C00 + {7'b0, offs[1]}, 8'h00);
    endfunction

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main_seq
        stim_t     e;
        cpu_data_t got;
        int        cnt;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        sltsl_n     = 1'b1;
        cd_in       = 8'hFF;
        pend_addr   = 16'h0000;
        pend_flags  = FLAGS_IDLE;
        build_table();

        wait_cycles(5);     // still in reset
        check_msel("reset msel_n", 3'b111, msel_n);
        check_bit("reset datadir", 1'b1, datadir);
        check_byte("reset cd_out", 8'hFF, cd_out);
        check_mapper("reset mapper_type", MAP_KONAMI_SCC, mapper_type);
        check_bit("reset scc_enable", 1'b1, scc_enable);
        check_vol("reset scc_vol", 4'd0, scc_vol);
        check_vol("reset psg_vol", 4'd0, psg_vol);
        check_vol("reset opll_vol", 4'd0, opll_vol);
        check_bit("reset sd_enabled", 1'b0, sd_enabled);

        cnt = 0;
        while (ram_enabled_w !== 1'b1 && cnt < 20) begin
            @(negedge clk108_w);
            cnt++;
        end
        if (ram_enabled_w !== 1'b1) begin
            $display("timeout: reset was never released");
            abort_run();
        end
        wait_msel(3'b110, 8);
        wait_msel(3'b101, 8);
        wait_msel(3'b011, 8);
        wait_msel(3'b111, 8);

        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            case (e.kind)
                IO_WR:  io_write(e);
                MEM_WR: mem_write(e);
                default: begin
                    mem_read(e, got);
                    check_byte(entry_name(i, "cd_out"), e.exp_rd, got);
                end
            endcase
            check_state(i, e);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk108_w,
    output logic ram_enabled_w
);

    initial begin
        clk108_w = 1'b0;
        forever #(PERIOD_NS / 2) clk108_w = ~clk108_w;
    end

    // reset low from time zero, released on a falling edge
    initial begin
        ram_enabled_w = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk108_w);
        ram_enabled_w = 1'b1;
    end

endmodule

/* logic/cart_top.sv */
`timescale 1ns/10ps

module cart_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                       clk108_w,
    input  logic                       ram_enabled_w,
    input  cart_bus_pkg::cpu_data_t    mp,
    input  logic                       rd_n,
    input  logic                       wr_n,
    input  logic                       sltsl_n,
    input  cart_bus_pkg::cpu_data_t    cd_in,
    output cart_bus_pkg::msel_t        msel_n,
    output cart_bus_pkg::cpu_data_t    cd_out,
    output logic                       datadir,
    output logic                       sd_enabled,
    output cart_bus_pkg::mapper_type_e mapper_type,
    output logic                       scc_enable,
    output cart_bus_pkg::vol_t         scc_vol,
    output cart_bus_pkg::vol_t         psg_vol,
    output cart_bus_pkg::vol_t         opll_vol
);
    import cart_bus_pkg::*;

    cpu_addr_t addr;
    logic      merq_n;
    logic      iorq_n;
    logic      m1_n;
    logic      sltsl_active;
    logic      wr_strobe;
    logic      rd_strobe;
    logic      rd_active;
    cpu_data_t buf_data;
    logic      buf_valid;

    ////////////////////////////////////////////////////////////
    // cartridge bus front end
    ////////////////////////////////////////////////////////////

    bus_demux #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_bus_demux (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .addr          (addr),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .sltsl_active  (sltsl_active),
        .wr_strobe     (wr_strobe),
        .rd_strobe     (rd_strobe),
        .rd_active     (rd_active)
    );

    config_port u_config_port (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .addr          (addr),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .wr_strobe     (wr_strobe),
        .cd_in         (cd_in),
        .mapper_type   (mapper_type),
        .scc_enable    (scc_enable),
        .scc_vol       (scc_vol),
        .psg_vol       (psg_vol),
        .opll_vol      (opll_vol)
    );

    sector_buffer u_sector_buffer (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .addr          (addr),
        .merq_n        (merq_n),
        .iorq_n        (iorq_n),
        .m1_n          (m1_n),
        .sltsl_active  (sltsl_active),
        .wr_strobe     (wr_strobe),
        .rd_strobe     (rd_strobe),
        .cd_in         (cd_in),
        .sd_enabled    (sd_enabled),
        .buf_data      (buf_data),
        .buf_valid     (buf_valid)
    );

    cart_bus_driver u_cart_bus_driver (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .rd_active     (rd_active),
        .rd_strobe     (rd_strobe),
        .buf_valid     (buf_valid),
        .buf_data      (buf_data),
        .cd_out        (cd_out),
        .datadir       (datadir)
    );

endmodule

/* logic/cart_bus_driver.sv */
`timescale 1ns/10ps

module cart_bus_driver (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  logic                    rd_active,
    input  logic                    rd_strobe,
    input  logic                    buf_valid,
    input  cart_bus_pkg::cpu_data_t buf_data,
    output cart_bus_pkg::cpu_data_t cd_out,
    output logic                    datadir
);
    import cart_bus_pkg::*;

    logic ff_rd_pend;   // read issued last cycle

    ////////////////////////////////////////////////////////////
    // data bus direction and read data
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            datadir    <= 1'b1;             // bus towards the cartridge
            ff_rd_pend <= 1'b0;
            cd_out     <= BUS_IDLE_BYTE;
        end else begin
            datadir    <= ~rd_active;
            ff_rd_pend <= rd_strobe;
            if (buf_valid) begin
                cd_out <= buf_data;
            end else if (ff_rd_pend) begin
                cd_out <= BUS_IDLE_BYTE;    // nobody answered
            end
        end
    end

endmodule

/* logic/sector_buffer.sv */
`timescale 1ns/10ps

module sector_buffer (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  cart_bus_pkg::cpu_addr_t addr,
    input  logic                    merq_n,
    input  logic                    iorq_n,
    input  logic                    m1_n,
    input  logic                    sltsl_active,
    input  logic                    wr_strobe,
    input  logic                    rd_strobe,
    input  cart_bus_pkg::cpu_data_t cd_in,
    output logic                    sd_enabled,
    output cart_bus_pkg::cpu_data_t buf_data,
    output logic                    buf_valid
);
    import cart_bus_pkg::*;

    cpu_data_t  ff_mem [512];
    logic       mem_cycle;
    logic       in_window;
    logic       at_enable;
    logic       buf_hit;
    logic [8:0] offset;

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////

    // plain memory cycle in our slot
    assign mem_cycle = sltsl_active & ~merq_n & iorq_n & m1_n;
    assign in_window = (addr >= SDC_SDATA) && (addr < SDC_ENABLE);
    assign at_enable = (addr == SDC_ENABLE);
    assign buf_hit   = mem_cycle & in_window & sd_enabled;
    assign offset    = addr[8:0];

    ////////////////////////////////////////////////////////////
    // enable register and read answer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            sd_enabled <= 1'b0;
            buf_valid  <= 1'b0;
        end else begin
            if (wr_strobe && mem_cycle && at_enable) begin
                sd_enabled <= cd_in[0];
            end
            // enable reg answers even while the buffer is off
            buf_valid <= rd_strobe & (buf_hit | (mem_cycle & at_enable));
        end
    end

    // sector storage, cpu port only
    always_ff @(posedge clk108_w) begin
        if (wr_strobe && buf_hit) begin
            ff_mem[offset] <= cd_in;
        end
        if (rd_strobe) begin
            if (at_enable) begin
                buf_data <= {7'b0, sd_enabled};
            end else begin
                buf_data <= ff_mem[offset];
            end
        end
    end

endmodule

/* logic/config_port.sv */
`timescale 1ns/10ps

module config_port (
    input  logic                         clk108_w,
    input  logic                         ram_enabled_w,
    input  cart_bus_pkg::cpu_addr_t      addr,
    input  logic                         iorq_n,
    input  logic                         m1_n,
    input  logic                         wr_strobe,
    input  cart_bus_pkg::cpu_data_t      cd_in,
    output cart_bus_pkg::mapper_type_e   mapper_type,
    output logic                         scc_enable,
    output cart_bus_pkg::vol_t           scc_vol,
    output cart_bus_pkg::vol_t           psg_vol,
    output cart_bus_pkg::vol_t           opll_vol
);
    import cart_bus_pkg::*;

    logic port_hit;
    vol_t new_vol;

    // io write to 8fh, not an interrupt ack
    assign port_hit = wr_strobe & ~iorq_n & m1_n & (addr[7:0] == CFG_PORT[7:0]);
    assign new_vol  = VOL_BASE - cd_in[3:0];    // wraps in 4 bits

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= MAP_KONAMI_SCC;
            scc_enable  <= 1'b1;
            scc_vol     <= '0;
            psg_vol     <= '0;
            opll_vol    <= '0;
        end else if (port_hit) begin
            // mapper opcodes
            case (cd_in)
                CMD_KONAMI_SCC: begin
                    mapper_type <= MAP_KONAMI_SCC;
                    scc_enable  <= 1'b1;
                end
                CMD_ASCII16: begin
                    mapper_type <= MAP_ASCII16;
                    scc_enable  <= 1'b0;
                end
                CMD_ASCII8: begin
                    mapper_type <= MAP_ASCII8;
                    scc_enable  <= 1'b0;
                end
                CMD_KONAMI: begin
                    mapper_type <= MAP_KONAMI;
                    scc_enable  <= 1'b0;
                end
                default: ;
            endcase

            // volume writes, decoded apart from the opcodes
            case (cd_in[7:4])
                VOL_SCC:  scc_vol  <= new_vol;
                VOL_PSG:  psg_vol  <= new_vol;
                VOL_OPLL: opll_vol <= new_vol;
                default: ;
            endcase
        end
    end

endmodule

/* logic/bus_demux.sv */
`timescale 1ns/10ps

module bus_demux #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                    clk108_w,
    input  logic                    ram_enabled_w,
    input  cart_bus_pkg::cpu_data_t mp,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    sltsl_n,
    output cart_bus_pkg::msel_t     msel_n,
    output cart_bus_pkg::cpu_addr_t addr,
    output logic                    merq_n,
    output logic                    iorq_n,
    output logic                    m1_n,
    output logic                    sltsl_active,
    output logic                    wr_strobe,
    output logic                    rd_strobe,
    output logic                    rd_active
);
    import cart_bus_pkg::*;

    mux_phase_e ff_phase;
    cpu_data_t  ff_low;
    cpu_data_t  ff_high;
    logic [2:0] ff_sync [SYNC_STAGES];  // {sltsl_n, wr_n, rd_n}
    logic [1:0] ff_last;                // {wr_n, rd_n} one cycle behind
    logic [2:0] pins;

    ////////////////////////////////////////////////////////////
    // mux sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ff_phase <= PH_IDLE;
            msel_n   <= 3'b111;
        end else begin
            case (ff_phase)
                PH_IDLE: begin
                    msel_n   <= 3'b110;         // a0-a7
                    ff_phase <= PH_LOW_SET;
                end
                PH_LOW_SET:     ff_phase <= PH_LOW_SAMPLE;
                PH_LOW_SAMPLE: begin
                    msel_n   <= 3'b101;         // a8-a15
                    ff_phase <= PH_HIGH_SET;
                end
                PH_HIGH_SET:    ff_phase <= PH_HIGH_SAMPLE;
                PH_HIGH_SAMPLE: begin
                    msel_n   <= 3'b011;         // merq, iorq, m1 ...
                    ff_phase <= PH_CTRL_SET;
                end
                PH_CTRL_SET:    ff_phase <= PH_CTRL_SAMPLE;
                default: begin
                    msel_n   <= 3'b111;
                    ff_phase <= PH_IDLE;
                end
            endcase
        end
    end

    // address bytes, published together with the flags
    always_ff @(posedge clk108_w) begin
        if (ff_phase == PH_LOW_SAMPLE) ff_low <= mp;
        if (ff_phase == PH_HIGH_SAMPLE) ff_high <= mp;
        if (ff_phase == PH_CTRL_SAMPLE) addr <= {ff_high, ff_low};
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            merq_n <= 1'b1;
            iorq_n <= 1'b1;
            m1_n   <= 1'b1;
        end else if (ff_phase == PH_CTRL_SAMPLE) begin
            merq_n <= mp[0];
            iorq_n <= mp[1];
            m1_n   <= mp[7];
        end
    end

    ////////////////////////////////////////////////////////////
    // strobe sync and edge detect
    ////////////////////////////////////////////////////////////

    assign pins = ff_sync[SYNC_STAGES-1];

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                ff_sync[i] <= 3'b111;
            end
            ff_last      <= 2'b11;
            wr_strobe    <= 1'b0;
            rd_strobe    <= 1'b0;
            sltsl_active <= 1'b0;
        end else begin
            ff_sync[0] <= {sltsl_n, wr_n, rd_n};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                ff_sync[i] <= ff_sync[i-1];
            end
            ff_last      <= pins[1:0];
            wr_strobe    <= ff_last[1] & ~pins[1];              // io or slot write
            rd_strobe    <= ff_last[0] & ~pins[0] & ~pins[2];   // slot reads only
            sltsl_active <= ~pins[2];
        end
    end

    assign rd_active = ~pins[0] & ~pins[2];

endmodule

/* logic/cart_bus_pkg.sv */
package cart_bus_pkg;

    ////////////////////////////////////////////////////////////
    // bus types
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [2:0]  msel_t;        // active low: bit0 a0-a7, bit1 a8-a15, bit2 flags
    typedef logic [3:0]  vol_t;

    // mux sequencer, a set/sample pair per group plus one idle slot
    typedef enum logic [2:0] {
        PH_LOW_SET,
        PH_LOW_SAMPLE,
        PH_HIGH_SET,
        PH_HIGH_SAMPLE,
        PH_CTRL_SET,
        PH_CTRL_SAMPLE,
        PH_IDLE
    } mux_phase_e;

    ////////////////////////////////////////////////////////////
    // config port encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MAP_KONAMI     = 2'd0,
        MAP_KONAMI_SCC = 2'd1,
        MAP_ASCII16    = 2'd2,
        MAP_ASCII8     = 2'd3
    } mapper_type_e;

    typedef enum logic [7:0] {
        CMD_KONAMI     = 8'h04,
        CMD_KONAMI_SCC = 8'h05,
        CMD_ASCII8     = 8'h08,
        CMD_ASCII16    = 8'h16
    } cfg_cmd_e;

    // high nibble picks the volume, low nibble is the attenuation
    typedef enum logic [3:0] {
        VOL_OPLL = 4'hD,
        VOL_PSG  = 4'hE,
        VOL_SCC  = 4'hF
    } vol_sel_e;

    localparam cpu_addr_t CFG_PORT   = 16'h008F;   // only low byte decoded
    localparam cpu_addr_t SDC_SDATA  = 16'h7C00;   // 512 byte sector window
    localparam cpu_addr_t SDC_ENABLE = 16'h7E00;

    localparam vol_t      VOL_BASE      = 4'd9;
    localparam cpu_data_t BUS_IDLE_BYTE = 8'hFF;

endpackage
